// ==== vlog.f ====
hdl/mul_pkg.sv
hdl/mul_op_if.sv
hdl/mul_array_core.sv
hdl/mul_lane.sv
hdl/mul_dispatch.sv
hdl/mul_collect.sv
hdl/mul_cluster.sv
bench/mul_cluster_assert.sv
bench/mul_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the multiply cluster testbench with Verilator, run it and check the log

rm -f sim.log

verilator --binary --timing --assert --top-module mul_cluster_tb \
    -f vlog.f -o mul_cluster_sim \
    && ./obj_dir/mul_cluster_sim > sim.log 2>&1

grep -qx "No errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== bench/mul_cluster_tb.sv ====
// Testbench for the multiply cluster with stimulus table, reference model, checks and watchdog
`timescale 1ns/100ps

module mul_cluster_tb;

    // ==================================================
    // Signals and stimulus table
    // ==================================================

    localparam int NUM_TESTS = 64;
    localparam int DRIVE_DELAY = 10;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;

    logic                clk;
    logic                rst_n;
    logic                req;
    logic                ack;
    mul_pkg::data_word_t multiplicand;
    mul_pkg::data_word_t multiplier;
    mul_pkg::mul_op_t    operation;
    logic                res_req;
    logic                res_ack;
    mul_pkg::data_word_t product;

    // Operand pairs, operation and model result of every entry
    mul_pkg::data_word_t tbl_a   [NUM_TESTS];
    mul_pkg::data_word_t tbl_b   [NUM_TESTS];
    mul_pkg::mul_op_t    tbl_op  [NUM_TESTS];
    mul_pkg::data_word_t tbl_exp [NUM_TESTS];

    // Results expected back in the order the requests were acknowledged
    mul_pkg::data_word_t exp_q [$];
    logic [31:0]         rng_state;
    int                  acked;
    // Result handshakes that have fully completed
    int                  responded;

    mul_cluster u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .req_i          (req),
        .ack_o          (ack),
        .multiplicand_i (multiplicand),
        .multiplier_i   (multiplier),
        .operation_i    (operation),
        .res_req_o      (res_req),
        .res_ack_i      (res_ack),
        .product_o      (product)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end : clock_gen

    // ==================================================
    // Reference model and helpers
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Each operand is extended by sign or by zero before one 64-bit product is formed
    function automatic mul_pkg::data_word_t model_result(input mul_pkg::data_word_t a,
                                                         input mul_pkg::data_word_t b,
                                                         input mul_pkg::mul_op_t op);
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        ext_a = (op != mul_pkg::MULHU) ? {{32{a[31]}}, a} : {32'd0, a};
        ext_b = (op == mul_pkg::MUL || op == mul_pkg::MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        prod = ext_a * ext_b;
        return (op == mul_pkg::MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, actual,
                     expected);
            abort_run();
        end
    endtask

    // Moves to the drive point just after the next rising edge
    task automatic next_drive_slot();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic set_entry(input int idx, input mul_pkg::data_word_t a,
                             input mul_pkg::data_word_t b, input mul_pkg::mul_op_t op);
        tbl_a[idx] = a;
        tbl_b[idx] = b;
        tbl_op[idx] = op;
        tbl_exp[idx] = model_result(a, b, op);
    endtask

    // Sign boundary cases come first and random entries fill the rest of the table
    task automatic fill_table();
        set_entry(0, 32'd7, 32'd6, mul_pkg::MUL);
        set_entry(1, 32'hFFFF_FFFD, 32'd5, mul_pkg::MUL);
        set_entry(2, 32'h8000_0000, 32'hFFFF_FFFF, mul_pkg::MUL);
        set_entry(3, 32'hFFFF_FFFF, 32'hFFFF_FFFF, mul_pkg::MUL);
        set_entry(4, 32'h8000_0000, 32'h8000_0000, mul_pkg::MULH);
        set_entry(5, 32'h0000_0000, 32'h8000_0000, mul_pkg::MULH);
        set_entry(6, 32'h1234_5678, 32'h0000_0000, mul_pkg::MULH);
        set_entry(7, 32'h7FFF_FFFF, 32'h8000_0000, mul_pkg::MULH);
        set_entry(8, 32'hFFFF_FFFF, 32'hFFFF_FFFF, mul_pkg::MULHSU);
        set_entry(9, 32'h8000_0000, 32'hFFFF_FFFF, mul_pkg::MULHSU);
        set_entry(10, 32'h7FFF_FFFF, 32'hFFFF_FFFF, mul_pkg::MULHSU);
        set_entry(11, 32'hFFFF_FFFF, 32'hFFFF_FFFF, mul_pkg::MULHU);
        set_entry(12, 32'h8000_0000, 32'h8000_0000, mul_pkg::MULHU);
        set_entry(13, 32'hDEAD_BEEF, 32'h0000_CAFE, mul_pkg::MULHU);
        for (int i = 14; i < NUM_TESTS; i++) begin
            logic [31:0] a;
            logic [31:0] b;
            rng_state = xorshift32(rng_state);
            a = rng_state;
            rng_state = xorshift32(rng_state);
            b = rng_state;
            rng_state = xorshift32(rng_state);
            set_entry(i, a, b, mul_pkg::mul_op_t'(rng_state[1:0]));
        end
    endtask

    // ==================================================
    // Request and response handshakes
    // ==================================================

    task automatic run_requests();
        for (int i = 0; i < NUM_TESTS; i++) begin
            multiplicand = tbl_a[i];
            multiplier = tbl_b[i];
            operation = tbl_op[i];
            req = 1'b1;
            do begin
                next_drive_slot();
            end while (!ack);
            acked++;
            exp_q.push_back(tbl_exp[i]);
            // Credits bound how far the request side may run ahead of the responses
            check_value("requests acknowledged ahead of responses",
                        32'((acked - responded) > mul_pkg::MAX_OUTSTANDING), 32'd0);
            req = 1'b0;
            do begin
                next_drive_slot();
            end while (ack);
        end
    endtask

    task automatic run_responses();
        int delay;
        for (int i = 0; i < NUM_TESTS; i++) begin
            do begin
                next_drive_slot();
            end while (!res_req);
            if (exp_q.size() == 0) begin
                $display("A result came back at %0d ns with no request pending", $time);
                abort_run();
            end else begin
                check_value("product_o", product, exp_q.pop_front());
                // Random back-pressure of 0 to 6 cycles before the acknowledge
                rng_state = xorshift32(rng_state);
                delay = int'(rng_state % 32'd7);
                repeat (delay) next_drive_slot();
                res_ack = 1'b1;
                do begin
                    next_drive_slot();
                end while (res_req);
                res_ack = 1'b0;
                // The buffer slot and its credit are free from here on
                responded++;
            end
        end
    endtask

    initial begin : main
        rng_state = 32'h55bd;
        acked = 0;
        responded = 0;
        rst_n = 1'b0;
        req = 1'b0;
        multiplicand = '0;
        multiplier = '0;
        operation = mul_pkg::MUL;
        res_ack = 1'b0;
        fill_table();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // Both handshakes stay idle until the first request
        next_drive_slot();
        next_drive_slot();
        check_value("ack_o", 32'(ack), 32'd0);
        check_value("res_req_o", 32'(res_req), 32'd0);
        fork
            run_requests();
            run_responses();
        join
        // Every request has been answered, so no further result may show up
        repeat (mul_pkg::LANE_LATENCY + 2) next_drive_slot();
        check_value("res_req_o", 32'(res_req), 32'd0);
        check_value("ack_o", 32'(ack), 32'd0);
        $display("No errors");
        $finish;
    end : main

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d clock cycles", TIMEOUT_CYCLES);
        abort_run();
    end : watchdog

endmodule

// ==== bench/mul_cluster_assert.sv ====
// Handshake assertions for the multiply cluster and their bind to the top level
`timescale 1ns/100ps

module mul_cluster_assert (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                req_i,
    input logic                ack_i,
    input logic                res_req_i,
    input logic                res_ack_i,
    input mul_pkg::data_word_t product_i
);

    // ==================================================
    // Input handshake
    // ==================================================

    // The acknowledge may only answer a request seen on the edge before
    ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose without a request on req_i");

    // ==================================================
    // Output handshake
    // ==================================================

    // An unanswered result request holds, and so does its data
    res_req_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_req_i && !res_ack_i) |=> (res_req_i && $stable(product_i)))
        else $error("res_req_o or product_o changed before res_ack_i");

    // A new result request waits for the previous acknowledge to drop
    res_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(res_req_i) |-> !$past(res_ack_i))
        else $error("res_req_o rose while res_ack_i was still high");

endmodule

bind mul_cluster mul_cluster_assert u_assert (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .ack_i     (ack_o),
    .res_req_i (res_req_o),
    .res_ack_i (res_ack_i),
    .product_i (product_o)
);

// ==== hdl/mul_cluster.sv ====
// Top level of the multiply cluster with the dispatcher, the lane array and the collector
`timescale 1ns/100ps

module mul_cluster (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    output logic                ack_o,
    input  mul_pkg::data_word_t multiplicand_i,
    input  mul_pkg::data_word_t multiplier_i,
    input  mul_pkg::mul_op_t    operation_i,
    output logic                res_req_o,
    input  logic                res_ack_i,
    output mul_pkg::data_word_t product_o
);

    // One issue bundle per lane
    mul_op_if lane_if [mul_pkg::NUM_LANES] ();

    logic [mul_pkg::NUM_LANES-1:0] lane_valid;
    mul_pkg::data_word_t           lane_result [mul_pkg::NUM_LANES];
    logic                          retire;

    mul_dispatch u_dispatch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .ack_o          (ack_o),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .operation_i    (operation_i),
        .retire_i       (retire),
        .lane_if        (lane_if)
    );

    // ==================================================
    // Multiplication lanes
    // ==================================================

    for (genvar l = 0; l < mul_pkg::NUM_LANES; l++) begin : g_lane
        mul_lane u_lane (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .op_if          (lane_if[l]),
            .result_valid_o (lane_valid[l]),
            .result_o       (lane_result[l])
        );
    end

    // Results leave in issue order and their retire frees the credits
    mul_collect u_collect (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .lane_valid_i  (lane_valid),
        .lane_result_i (lane_result),
        .res_req_o     (res_req_o),
        .res_ack_i     (res_ack_i),
        .product_o     (product_o),
        .retire_o      (retire)
    );

endmodule

// ==== hdl/mul_collect.sv ====
// Collector with the in-order result FIFO, output four-phase handshake and retire pulse
`timescale 1ns/100ps

module mul_collect (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [mul_pkg::NUM_LANES-1:0] lane_valid_i,
    input  mul_pkg::data_word_t          lane_result_i [mul_pkg::NUM_LANES],
    output logic                         res_req_o,
    input  logic                         res_ack_i,
    output mul_pkg::data_word_t          product_o,
    output logic                         retire_o
);

    mul_pkg::data_word_t               buf_mem [mul_pkg::MAX_OUTSTANDING];
    logic [mul_pkg::BUF_IDX_WIDTH-1:0] wr_ptr;
    logic [mul_pkg::BUF_IDX_WIDTH-1:0] rd_ptr;
    logic [mul_pkg::CREDIT_WIDTH-1:0]  count;
    mul_pkg::data_word_t               wr_data;
    logic                              push;
    logic                              pop;
    logic                              res_req_q;

    // Buffer index step with wrap at the buffer depth
    function automatic logic [mul_pkg::BUF_IDX_WIDTH-1:0] next_idx(
        input logic [mul_pkg::BUF_IDX_WIDTH-1:0] idx
    );
        return (idx == mul_pkg::BUF_IDX_WIDTH'(mul_pkg::MAX_OUTSTANDING - 1)) ? '0 : idx + 1'b1;
    endfunction

    // ==================================================
    // Result buffer
    // ==================================================

    // Issue is one per cycle and latency is shared, so at most one lane fires
    // Results therefore arrive already in issue order
    assign push = |lane_valid_i;

    always_comb begin : lane_select
        wr_data = lane_result_i[0];
        for (int l = 1; l < mul_pkg::NUM_LANES; l++) begin
            if (lane_valid_i[l]) begin
                wr_data = lane_result_i[l];
            end
        end
    end : lane_select

    always_ff @(posedge clk_i) begin : buf_write
        if (push) begin
            buf_mem[wr_ptr] <= wr_data;
        end
    end : buf_write

    // ==================================================
    // Output handshake
    // ==================================================

    // A handshake completes when the sink acknowledges a raised request
    assign pop = res_req_q & res_ack_i;

    always_ff @(posedge clk_i) begin : ctrl_reg
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            res_req_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_idx(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_idx(rd_ptr);
            end
            if (push & ~pop) begin
                count <= count + 1'b1;
            end else if (pop & ~push) begin
                count <= count - 1'b1;
            end
            // The next request waits for the previous acknowledge to drop
            if (pop) begin
                res_req_q <= 1'b0;
            end else if (!res_req_q && !res_ack_i && (count != '0)) begin
                res_req_q <= 1'b1;
            end
        end
    end : ctrl_reg

    // The head entry stays put until the pop, so product_o is stable under req
    assign product_o = buf_mem[rd_ptr];
    assign res_req_o = res_req_q;

    // Every completed handshake gives one credit back to the dispatcher
    assign retire_o = pop;

endmodule

// ==== hdl/mul_dispatch.sv ====
// Dispatcher with the input four-phase handshake, credit counter and round-robin lane select
`timescale 1ns/100ps

module mul_dispatch (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    output logic                ack_o,
    input  mul_pkg::data_word_t multiplicand_i,
    input  mul_pkg::data_word_t multiplier_i,
    input  mul_pkg::mul_op_t    operation_i,
    input  logic                retire_i,
    mul_op_if.dispatcher        lane_if [mul_pkg::NUM_LANES]
);

    logic                               ack_q;
    logic                               accept;
    logic                               credit_free;
    logic [mul_pkg::CREDIT_WIDTH-1:0]   credits;
    logic [mul_pkg::LANE_IDX_WIDTH-1:0] lane_ptr;

    // ==================================================
    // Input handshake
    // ==================================================

    // A full credit count means the result buffer may already be full
    assign credit_free = (credits != mul_pkg::CREDIT_WIDTH'(mul_pkg::MAX_OUTSTANDING));

    // A request is taken in the idle phase only, and only with a credit left
    assign accept = req_i & ~ack_q & credit_free;

    // Ack rises on the accepting edge and falls one cycle after req_i drops
    always_ff @(posedge clk_i) begin : ack_reg
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (!req_i) begin
            ack_q <= 1'b0;
        end
    end : ack_reg

    assign ack_o = ack_q;

    // One credit per operation between accept and retire
    always_ff @(posedge clk_i) begin : credit_reg
        if (!rst_n_i) begin
            credits <= '0;
        end else if (accept & ~retire_i) begin
            credits <= credits + 1'b1;
        end else if (retire_i & ~accept) begin
            credits <= credits - 1'b1;
        end
    end : credit_reg

    // ==================================================
    // Lane selection
    // ==================================================

    always_ff @(posedge clk_i) begin : lane_ptr_reg
        if (!rst_n_i) begin
            lane_ptr <= '0;
        end else if (accept) begin
            lane_ptr <= (lane_ptr == mul_pkg::LANE_IDX_WIDTH'(mul_pkg::NUM_LANES - 1)) ?
                        '0 : lane_ptr + 1'b1;
        end
    end : lane_ptr_reg

    // Operands go to every lane and only the selected one sees the strobe
    for (genvar l = 0; l < mul_pkg::NUM_LANES; l++) begin : g_issue
        assign lane_if[l].valid = accept & (lane_ptr == mul_pkg::LANE_IDX_WIDTH'(l));
        assign lane_if[l].multiplicand = multiplicand_i;
        assign lane_if[l].multiplier = multiplier_i;
        assign lane_if[l].operation = operation_i;
    end

endmodule

// ==== hdl/mul_lane.sv ====
// Signed and unsigned RV32M multiplication lane around the array core with its own clock enable
`timescale 1ns/100ps

module mul_lane (
    input  logic                clk_i,
    input  logic                rst_n_i,
    mul_op_if.lane              op_if,
    output logic                result_valid_o,
    output mul_pkg::data_word_t result_o
);

    // One valid bit per lane stage, the last one flags the result
    logic [mul_pkg::LANE_LATENCY-1:0] valid_pipe;
    logic                             clk_en;

    // The lane only toggles while it has an operation inside or one arriving
    // All stages advance together, which keeps the latency fixed
    assign clk_en = op_if.valid | (|valid_pipe);

    // ==================================================
    // First stage
    // ==================================================

    logic                rs1_signed;
    logic                rs2_signed;
    logic                rs1_neg;
    logic                rs2_neg;
    mul_pkg::data_word_t mcand_abs;
    mul_pkg::data_word_t mplier_abs;

    // The multiplicand is signed for everything but MULHU
    assign rs1_signed = (op_if.operation != mul_pkg::MULHU);

    // The multiplier is signed only for MUL and MULH
    assign rs2_signed = (op_if.operation == mul_pkg::MUL) |
                        (op_if.operation == mul_pkg::MULH);

    assign rs1_neg = rs1_signed & op_if.multiplicand[mul_pkg::DATA_WIDTH-1];
    assign rs2_neg = rs2_signed & op_if.multiplier[mul_pkg::DATA_WIDTH-1];

    // The core is unsigned, so negative signed operands enter as magnitudes
    assign mcand_abs = rs1_neg ? (~op_if.multiplicand + 1'b1) : op_if.multiplicand;
    assign mplier_abs = rs2_neg ? (~op_if.multiplier + 1'b1) : op_if.multiplier;

    // ==================================================
    // Core and side pipelines
    // ==================================================

    mul_pkg::data_word_t               mcand_q;
    mul_pkg::data_word_t               mplier_q;
    logic [mul_pkg::LANE_LATENCY-1:0]  neg_pipe;
    mul_pkg::mul_op_t                  op_pipe [mul_pkg::LANE_LATENCY];
    logic [mul_pkg::PRODUCT_WIDTH-1:0] core_product;
    logic [mul_pkg::PRODUCT_WIDTH-1:0] product_q;

    // Payload registers, their content is qualified by valid_pipe
    always_ff @(posedge clk_i) begin : datapath_reg
        if (clk_en) begin
            mcand_q <= mcand_abs;
            mplier_q <= mplier_abs;
            // Exactly one negative factor means the product must be negated
            neg_pipe <= {neg_pipe[mul_pkg::LANE_LATENCY-2:0], rs1_neg ^ rs2_neg};
            op_pipe[0] <= op_if.operation;
            for (int i = 1; i < mul_pkg::LANE_LATENCY; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
            product_q <= core_product;
        end
    end : datapath_reg

    always_ff @(posedge clk_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else if (clk_en) begin
            valid_pipe <= {valid_pipe[mul_pkg::LANE_LATENCY-2:0], op_if.valid};
        end
    end : valid_reg

    mul_array_core u_core (
        .clk_i          (clk_i),
        .clk_en_i       (clk_en),
        .multiplicand_i (mcand_q),
        .multiplier_i   (mplier_q),
        .product_o      (core_product)
    );

    // ==================================================
    // Last stage
    // ==================================================

    logic [mul_pkg::PRODUCT_WIDTH-1:0] product_fix;

    assign product_fix = neg_pipe[mul_pkg::LANE_LATENCY-1] ? (~product_q + 1'b1) : product_q;

    // MUL keeps the low word, the three high variants keep the upper one
    assign result_o = (op_pipe[mul_pkg::LANE_LATENCY-1] == mul_pkg::MUL) ?
                      product_fix[mul_pkg::DATA_WIDTH-1:0] :
                      product_fix[mul_pkg::PRODUCT_WIDTH-1:mul_pkg::DATA_WIDTH];

    assign result_valid_o = valid_pipe[mul_pkg::LANE_LATENCY-1];

endmodule

// ==== hdl/mul_array_core.sv ====
// Unsigned pipelined array multiplier made of registered partial product slices
`timescale 1ns/100ps

module mul_array_core (
    input  logic                              clk_i,
    input  logic                              clk_en_i,
    input  mul_pkg::data_word_t               multiplicand_i,
    input  mul_pkg::data_word_t               multiplier_i,
    output logic [mul_pkg::PRODUCT_WIDTH-1:0] product_o
);

    // ==================================================
    // Partial product slices
    // ==================================================

    // Each slice adds CORE_ROWS shifted copies of the multiplicand to the running sum
    // The operands ride along with the sum so every slice works on its own operation
    // Nothing moves unless clk_en_i is high
    for (genvar s = 0; s < mul_pkg::CORE_STAGES; s++) begin : g_stage
        logic [mul_pkg::PRODUCT_WIDTH-1:0] acc_in;
        logic [mul_pkg::PRODUCT_WIDTH-1:0] acc_sum;
        logic [mul_pkg::PRODUCT_WIDTH-1:0] acc_q;
        mul_pkg::data_word_t               mcand_in;
        mul_pkg::data_word_t               mplier_in;

        if (s == 0) begin : g_head
            // The first slice starts from an empty sum and reads the ports
            assign acc_in = '0;
            assign mcand_in = multiplicand_i;
            assign mplier_in = multiplier_i;
        end else begin : g_tail
            mul_pkg::data_word_t mcand_q;
            mul_pkg::data_word_t mplier_q;

            // Operand copy for this slice, taken from the slice in front
            always_ff @(posedge clk_i) begin : operand_reg
                if (clk_en_i) begin
                    mcand_q <= g_stage[s-1].mcand_in;
                    mplier_q <= g_stage[s-1].mplier_in;
                end
            end : operand_reg

            assign acc_in = g_stage[s-1].acc_q;
            assign mcand_in = mcand_q;
            assign mplier_in = mplier_q;
        end

        // Rows whose multiplier bit is clear add nothing
        // The bound check only matters when DATA_WIDTH does not split evenly
        always_comb begin : row_sum
            acc_sum = acc_in;
            for (int r = 0; r < mul_pkg::CORE_ROWS; r++) begin
                if ((s * mul_pkg::CORE_ROWS + r) < mul_pkg::DATA_WIDTH) begin
                    if (mplier_in[s * mul_pkg::CORE_ROWS + r]) begin
                        acc_sum = acc_sum + ({{mul_pkg::DATA_WIDTH{1'b0}}, mcand_in}
                                             << (s * mul_pkg::CORE_ROWS + r));
                    end
                end
            end
        end : row_sum

        always_ff @(posedge clk_i) begin : slice_reg
            if (clk_en_i) begin
                acc_q <= acc_sum;
            end
        end : slice_reg
    end

    // The last slice holds the complete unsigned product
    assign product_o = g_stage[mul_pkg::CORE_STAGES-1].acc_q;

endmodule

// ==== hdl/mul_op_if.sv ====
// Issue interface that carries one operation from the dispatcher into a lane
`timescale 1ns/100ps

interface mul_op_if;

    // Single cycle strobe, a lane always takes what it is given
    logic                valid;

    // Operands are only meaningful in the cycle that valid is high
    mul_pkg::data_word_t multiplicand;
    mul_pkg::data_word_t multiplier;

    // Decides signedness of the operands and which product word is returned
    mul_pkg::mul_op_t    operation;

    // The dispatcher owns every signal of the bundle
    modport dispatcher (
        output valid,
        output multiplicand,
        output multiplier,
        output operation
    );

    // A lane only listens
    modport lane (
        input valid,
        input multiplicand,
        input multiplier,
        input operation
    );

endinterface

// ==== hdl/mul_pkg.sv ====
// Multiply cluster package with sizes, counter widths, the data word type and the operation enum
package mul_pkg;

    // ==================================================
    // Datapath sizes
    // ==================================================

    // Width of one operand and of one result word
    localparam int DATA_WIDTH = 32;

    // The full product is twice as wide as an operand
    localparam int PRODUCT_WIDTH = 2 * DATA_WIDTH;

    // Register slices inside the array core, any value of 1 or more works
    localparam int CORE_STAGES = 2;

    // Partial product rows summed by one core slice, rounded up
    localparam int CORE_ROWS = (DATA_WIDTH + CORE_STAGES - 1) / CORE_STAGES;

    // Operand register in front of the core plus the output register after it
    localparam int LANE_LATENCY = CORE_STAGES + 2;

    // ==================================================
    // Cluster organisation
    // ==================================================

    localparam int NUM_LANES = 2;
    localparam int LANE_IDX_WIDTH = 1;

    // Operations accepted but not yet returned, also the result buffer depth
    localparam int MAX_OUTSTANDING = 4;

    // The credit count has to reach MAX_OUTSTANDING itself
    localparam int CREDIT_WIDTH = $clog2(MAX_OUTSTANDING + 1);
    localparam int BUF_IDX_WIDTH = $clog2(MAX_OUTSTANDING);

    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Encoded like the low two funct3 bits of the RV32M multiply group
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_t;

endpackage
